//--- msx_pkg.sv
`default_nettype none

package msx_pkg;

    ////////////////////////////////////////
    // widths with a meaning
    typedef logic [15:0] addr_t;        // z80 address
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] sector_t;      // sd sector number
    typedef logic [2:0]  msel_t;        // active low mux select
    typedef logic [1:0]  mapper_type_t;

    // pin scanner sequence, one state per clock
    typedef enum logic [2:0] {
        SCAN_LO_SEL,
        SCAN_LO_CAP,
        SCAN_HI_SEL,
        SCAN_HI_CAP,
        SCAN_CTL_SEL,
        SCAN_CTL_CAP,
        SCAN_IDLE
    } scan_state_e;

    ////////////////////////////////////////
    // bus and sd register window
    localparam addr_t SDC_BASE       = 16'h7E00;
    localparam byte_t SDC_OFF_ENABLE = 8'h00;
    localparam byte_t SDC_OFF_CMD    = 8'h01;
    localparam byte_t SDC_OFF_STATUS = 8'h02;
    localparam byte_t SDC_OFF_SADDR  = 8'h03;    // four bytes, lsb first
    localparam byte_t SDC_OFF_CTYPE  = 8'h0E;
    localparam byte_t SDC_OFF_MID    = 8'h0F;
    localparam byte_t UNMAPPED_BYTE  = 8'hFF;

    // command register bits
    localparam int CMD_BIT_RSTART = 0;
    localparam int CMD_BIT_WSTART = 1;
    localparam int CMD_BIT_INIT   = 7;

    // mapper config port and the codes written to it
    localparam byte_t MAPPER_PORT  = 8'h8F;
    localparam byte_t CFG_KONAMI   = 8'h04;
    localparam byte_t CFG_SCC_PLUS = 8'h05;
    localparam byte_t CFG_ASCII16  = 8'h16;
    localparam byte_t CFG_ASCII8   = 8'h08;

    localparam mapper_type_t MAP_KONAMI   = 2'd0;
    localparam mapper_type_t MAP_SCC_PLUS = 2'd1;
    localparam mapper_type_t MAP_ASCII16  = 2'd2;
    localparam mapper_type_t MAP_ASCII8   = 2'd3;

    ////////////////////////////////////////
    // external multiplexer
    localparam msel_t MSEL_LO   = 3'b110;   // a7..a0
    localparam msel_t MSEL_HI   = 3'b101;   // a15..a8
    localparam msel_t MSEL_CTL  = 3'b011;   // control pins
    localparam msel_t MSEL_NONE = 3'b111;

    // control group bit positions on mp
    localparam int CTL_BIT_MERQ = 0;
    localparam int CTL_BIT_IORQ = 1;
    localparam int CTL_BIT_M1   = 7;

    ////////////////////////////////////////
    typedef struct packed {
        addr_t addr;
        logic  rd_n;
        logic  wr_n;
        logic  iorq_n;
        logic  merq_n;
        logic  m1_n;
        logic  sltsl_n;
        byte_t data;        // cd_in as captured
    } bus_cycle_t;

    typedef struct packed {
        logic         sdc_wr;
        logic         sdc_rd;
        byte_t        reg_off;
        logic         cfg_wr;
        logic         cfg_ok;      // data is a known mapper code
        mapper_type_t cfg_type;
        byte_t        data;
    } sdc_req_t;

    typedef struct packed {
        logic       busy;
        logic       crc_error;
        logic       timeout_error;
        logic [1:0] card_type;
        byte_t      mid;
    } sdc_status_t;

    typedef struct packed {
        logic         sd_en;
        logic         rstart;
        logic         wstart;
        logic         init;
        sector_t      sector;
        mapper_type_t mapper_type;
        logic         scc_enable;
    } sdc_ctrl_t;

endpackage

`default_nettype wire

//--- bus_mux_scan.sv
`default_nettype none

module bus_mux_scan (
    input  logic                clk108_w,
    input  logic                ram_enabled_w,
    input  msx_pkg::byte_t      mp,
    input  msx_pkg::byte_t      cd_in,
    input  logic                rd_n,
    input  logic                wr_n,
    input  logic                sltsl_n,
    output msx_pkg::msel_t      msel_n,
    output msx_pkg::bus_cycle_t bus
);

    msx_pkg::scan_state_e state_q;
    msx_pkg::scan_state_e state_nxt;
    msx_pkg::msel_t       msel_nxt;
    msx_pkg::byte_t       addr_lo_q;
    msx_pkg::byte_t       addr_hi_q;
    logic [2:0]           strb_q;       // {rd_n, wr_n, sltsl_n} seen so far this sweep
    logic [2:0]           strb_pins;

    assign strb_pins = {rd_n, wr_n, sltsl_n};

    ////////////////////////////////////////
    // select sequence
    always_comb begin
        case (state_q)
            msx_pkg::SCAN_LO_SEL:  state_nxt = msx_pkg::SCAN_LO_CAP;
            msx_pkg::SCAN_LO_CAP:  state_nxt = msx_pkg::SCAN_HI_SEL;
            msx_pkg::SCAN_HI_SEL:  state_nxt = msx_pkg::SCAN_HI_CAP;
            msx_pkg::SCAN_HI_CAP:  state_nxt = msx_pkg::SCAN_CTL_SEL;
            msx_pkg::SCAN_CTL_SEL: state_nxt = msx_pkg::SCAN_CTL_CAP;
            msx_pkg::SCAN_CTL_CAP: state_nxt = msx_pkg::SCAN_IDLE;
            default:               state_nxt = msx_pkg::SCAN_LO_SEL;
        endcase
    end

    // msel_n is registered, so it follows the state we are going to
    always_comb begin
        case (state_nxt)
            msx_pkg::SCAN_LO_SEL,
            msx_pkg::SCAN_LO_CAP:  msel_nxt = msx_pkg::MSEL_LO;
            msx_pkg::SCAN_HI_SEL,
            msx_pkg::SCAN_HI_CAP:  msel_nxt = msx_pkg::MSEL_HI;
            msx_pkg::SCAN_CTL_SEL,
            msx_pkg::SCAN_CTL_CAP: msel_nxt = msx_pkg::MSEL_CTL;
            default:               msel_nxt = msx_pkg::MSEL_NONE;
        endcase
    end

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            state_q <= msx_pkg::SCAN_IDLE;
            msel_n  <= msx_pkg::MSEL_NONE;
        end else begin
            state_q <= state_nxt;
            msel_n  <= msel_nxt;
        end
    end

    ////////////////////////////////////////
    // capture into shadows, publish the whole cycle at ctl_cap
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            addr_lo_q   <= '0;
            addr_hi_q   <= '0;
            strb_q      <= '1;
            bus.addr    <= '0;
            bus.rd_n    <= 1'b1;
            bus.wr_n    <= 1'b1;
            bus.iorq_n  <= 1'b1;
            bus.merq_n  <= 1'b1;
            bus.m1_n    <= 1'b1;
            bus.sltsl_n <= 1'b1;
            bus.data    <= '0;
        end else begin
            case (state_q)
                msx_pkg::SCAN_LO_CAP: begin
                    addr_lo_q <= mp;
                    strb_q    <= strb_pins;            // sweep starts here
                end
                msx_pkg::SCAN_HI_CAP: begin
                    addr_hi_q <= mp;
                    strb_q    <= strb_q | strb_pins;   // any high sample drops the strobe
                end
                msx_pkg::SCAN_CTL_CAP: begin
                    bus.addr   <= {addr_hi_q, addr_lo_q};
                    bus.merq_n <= mp[msx_pkg::CTL_BIT_MERQ];
                    bus.iorq_n <= mp[msx_pkg::CTL_BIT_IORQ];
                    bus.m1_n   <= mp[msx_pkg::CTL_BIT_M1];
                    {bus.rd_n, bus.wr_n, bus.sltsl_n} <= strb_q | strb_pins;
                    bus.data   <= cd_in;
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- sdc_decode.sv
`default_nettype none

module sdc_decode (
    input  msx_pkg::bus_cycle_t bus,
    output msx_pkg::sdc_req_t   req
);

    logic slot_mem;     // memory cycle in our slot
    logic in_window;    // 7e00h..7effh
    logic io_wr;        // plain i/o write, no interrupt ack

    assign slot_mem  = !bus.sltsl_n && !bus.merq_n && bus.iorq_n && bus.m1_n;
    assign in_window = (bus.addr[15:8] == msx_pkg::SDC_BASE[15:8]);
    assign io_wr     = !bus.iorq_n && bus.m1_n && !bus.wr_n && bus.rd_n;

    always_comb begin
        req.sdc_wr  = slot_mem && in_window && !bus.wr_n;
        req.sdc_rd  = slot_mem && in_window && !bus.rd_n;
        req.reg_off = bus.addr[7:0];
        req.data    = bus.data;

        // mapper port only looks at the low address byte
        req.cfg_wr  = io_wr && (bus.addr[7:0] == msx_pkg::MAPPER_PORT);

        ////////////////////////////////////////
        // mapper code lookup
        req.cfg_ok = 1'b1;
        case (bus.data)
            msx_pkg::CFG_KONAMI: begin
                req.cfg_type = msx_pkg::MAP_KONAMI;
            end
            msx_pkg::CFG_SCC_PLUS: begin
                req.cfg_type = msx_pkg::MAP_SCC_PLUS;
            end
            msx_pkg::CFG_ASCII16: begin
                req.cfg_type = msx_pkg::MAP_ASCII16;
            end
            msx_pkg::CFG_ASCII8: begin
                req.cfg_type = msx_pkg::MAP_ASCII8;
            end
            default: begin
                req.cfg_ok   = 1'b0;   // unknown code, regs ignore it
                req.cfg_type = msx_pkg::MAP_KONAMI;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- sdc_regs.sv
`default_nettype none

module sdc_regs (
    input  logic                clk108_w,
    input  logic                ram_enabled_w,
    input  msx_pkg::sdc_req_t   req,
    input  logic                sd_done,
    output msx_pkg::sdc_ctrl_t  ctrl
);

    logic en_wr;    // write to the enable register
    logic reg_wr;   // any other register write, needs sd_en
    logic cmd_wr;
    logic cfg_ld;

    assign en_wr  = req.sdc_wr && (req.reg_off == msx_pkg::SDC_OFF_ENABLE);
    assign reg_wr = req.sdc_wr && ctrl.sd_en;
    assign cmd_wr = reg_wr && (req.reg_off == msx_pkg::SDC_OFF_CMD);
    assign cfg_ld = req.cfg_wr && req.cfg_ok;

    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            ctrl.sd_en       <= 1'b0;
            ctrl.rstart      <= 1'b0;
            ctrl.wstart      <= 1'b0;
            ctrl.init        <= 1'b0;
            ctrl.sector      <= '0;
            ctrl.mapper_type <= msx_pkg::MAP_SCC_PLUS;   // konami scc+ out of reset
            ctrl.scc_enable  <= 1'b1;
        end else begin
            if (en_wr) begin
                ctrl.sd_en <= req.data[0];
            end

            ////////////////////////////////////////
            // start flags are sticky until the engine is done
            if (cmd_wr) begin
                ctrl.rstart <= ctrl.rstart | req.data[msx_pkg::CMD_BIT_RSTART];
                ctrl.wstart <= ctrl.wstart | req.data[msx_pkg::CMD_BIT_WSTART];
                ctrl.init   <= ctrl.init   | req.data[msx_pkg::CMD_BIT_INIT];
            end
            if (sd_done) begin     // last assignment wins over cmd
                ctrl.rstart <= 1'b0;
                ctrl.wstart <= 1'b0;
            end

            // sector bytes, lsb at the lowest offset
            for (int n = 0; n < 4; n++) begin
                if (reg_wr && (req.reg_off == msx_pkg::SDC_OFF_SADDR + msx_pkg::byte_t'(n))) begin
                    ctrl.sector[8*n +: 8] <= req.data;
                end
            end

            ////////////////////////////////////////
            // mapper config from port 8fh
            if (cfg_ld) begin
                ctrl.mapper_type <= req.cfg_type;
                ctrl.scc_enable  <= (req.cfg_type == msx_pkg::MAP_SCC_PLUS);
            end
        end
    end

endmodule

`default_nettype wire

//--- sdc_readback.sv
`default_nettype none

module sdc_readback (
    input  logic                clk108_w,
    input  logic                ram_enabled_w,
    input  msx_pkg::sdc_req_t   req,
    input  msx_pkg::sdc_ctrl_t  ctrl,
    input  msx_pkg::sdc_status_t status,
    input  msx_pkg::bus_cycle_t bus,
    output msx_pkg::byte_t      cd_out,
    output logic                datadir
);

    logic rd_ok;        // register read while the window is enabled
    logic slot_rd;      // slot read as captured, cartridge owns the bus

    assign rd_ok   = req.sdc_rd && ctrl.sd_en;
    assign slot_rd = !bus.sltsl_n && !bus.rd_n;

    ////////////////////////////////////////
    // read data register
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            cd_out <= msx_pkg::UNMAPPED_BYTE;
        end else if (rd_ok) begin
            case (req.reg_off)
                msx_pkg::SDC_OFF_ENABLE: begin
                    cd_out <= {7'b0, ctrl.sd_en};
                end
                msx_pkg::SDC_OFF_STATUS: begin
                    cd_out <= {status.busy, 5'b0, status.timeout_error, status.crc_error};
                end
                msx_pkg::SDC_OFF_CTYPE: begin
                    cd_out <= {6'b0, status.card_type};   // 0 unknown, 3 sdhc
                end
                msx_pkg::SDC_OFF_MID: begin
                    cd_out <= status.mid;
                end
                default: begin
                    cd_out <= msx_pkg::UNMAPPED_BYTE;
                end
            endcase
        end
    end

    // direction, low drives cd towards the z80
    // registered so it lines up with cd_out
    always_ff @(posedge clk108_w or negedge ram_enabled_w) begin
        if (!ram_enabled_w) begin
            datadir <= 1'b1;
        end else begin
            datadir <= !slot_rd;
        end
    end

endmodule

`default_nettype wire

//--- msx_cart_top.sv
`default_nettype none

module msx_cart_top (
    input  logic                 clk108_w,
    input  logic                 ram_enabled_w,
    input  msx_pkg::byte_t       mp,
    input  msx_pkg::byte_t       cd_in,
    input  logic                 rd_n,
    input  logic                 wr_n,
    input  logic                 sltsl_n,
    input  logic                 sd_done,
    input  msx_pkg::sdc_status_t sd_status,
    output msx_pkg::msel_t       msel_n,
    output msx_pkg::byte_t       cd_out,
    output logic                 datadir,
    output msx_pkg::sdc_ctrl_t   sd_ctrl
);

    msx_pkg::bus_cycle_t bus;   // one coherent cycle per sweep
    msx_pkg::sdc_req_t   req;

    ////////////////////////////////////////
    bus_mux_scan scan_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .cd_in         (cd_in),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .msel_n        (msel_n),
        .bus           (bus)
    );

    sdc_decode decode_i (
        .bus (bus),
        .req (req)
    );

    sdc_regs regs_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .req           (req),
        .sd_done       (sd_done),
        .ctrl          (sd_ctrl)
    );

    sdc_readback readback_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .req           (req),
        .ctrl          (sd_ctrl),
        .status        (sd_status),
        .bus           (bus),
        .cd_out        (cd_out),
        .datadir       (datadir)
    );

endmodule

`default_nettype wire

//--- tb_checker.sv
`default_nettype none

module tb_checker (
    input  logic               clk108_w,
    input  logic               check,        // high for one clock at the end of a row
    input  logic [127:0]       name,
    input  msx_pkg::byte_t     exp_cd,
    input  logic               exp_dir,
    input  msx_pkg::sdc_ctrl_t exp_ctrl,
    input  msx_pkg::byte_t     cd_out,
    input  logic               datadir,
    input  msx_pkg::sdc_ctrl_t sd_ctrl,
    output int                 pass_count,
    output int                 fail_count
);

    initial begin
        pass_count = 0;
        fail_count = 0;
    end

    // one comparison per row at the end of its hold
    always @(posedge clk108_w) begin
        if (check) begin
            if (cd_out !== exp_cd || datadir !== exp_dir || sd_ctrl !== exp_ctrl) begin
                fail_count = fail_count + 1;
                $write("ERROR %0s expected cd_out=%h datadir=%b sd_ctrl=%h,",
                       name, exp_cd, exp_dir, exp_ctrl);
                $display(" actual cd_out=%h datadir=%b sd_ctrl=%h",
                         cd_out, datadir, sd_ctrl);
            end else begin
                pass_count = pass_count + 1;
                $display("ok    %0s cd_out=%h datadir=%b sd_ctrl=%h",
                         name, cd_out, datadir, sd_ctrl);
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_cart.sv
`default_nettype none

module tb_cart;

    localparam int HOLD_CYCLES = 32;
    localparam int IDLE_CYCLES = 16;
    localparam int ROW_CYCLES  = HOLD_CYCLES + IDLE_CYCLES;

    typedef enum logic [2:0] {K_IDLE, K_WR, K_RD, K_IO, K_DONE} kind_e;
    typedef enum logic [2:0] {CD_KEEP, CD_VAL, CD_STAT, CD_CTYPE, CD_MID} cd_src_e;

    typedef struct packed {
        logic [127:0]       name;
        kind_e              kind;
        msx_pkg::addr_t     addr;
        msx_pkg::byte_t     data;
        cd_src_e            cd_src;   // where the expected read byte comes from
        msx_pkg::byte_t     cd_val;
        logic               dir;
        msx_pkg::sdc_ctrl_t ctrl;
    } row_t;

    logic                 clk108_w;
    logic                 ram_enabled_w;
    msx_pkg::byte_t       mp;
    msx_pkg::byte_t       cd_in;
    logic                 rd_n;
    logic                 wr_n;
    logic                 sltsl_n;
    logic                 sd_done;
    msx_pkg::sdc_status_t sd_status;
    msx_pkg::msel_t       msel_n;
    msx_pkg::byte_t       cd_out;
    logic                 datadir;
    msx_pkg::sdc_ctrl_t   sd_ctrl;

    msx_pkg::bus_cycle_t  pins;       // what the z80 side shows right now
    row_t                 rows [0:31];
    int                   n_rows = 0;
    int                   cycles = 0;
    logic [31:0]          lfsr_q;
    logic                 check_now;
    logic [127:0]         cur_name;
    msx_pkg::byte_t       last_cd;
    msx_pkg::byte_t       exp_cd;
    logic                 exp_dir;
    msx_pkg::sdc_ctrl_t   exp_ctrl;
    int                   pass_count;
    int                   fail_count;

    msx_cart_top dut_i (
        .clk108_w      (clk108_w),
        .ram_enabled_w (ram_enabled_w),
        .mp            (mp),
        .cd_in         (cd_in),
        .rd_n          (rd_n),
        .wr_n          (wr_n),
        .sltsl_n       (sltsl_n),
        .sd_done       (sd_done),
        .sd_status     (sd_status),
        .msel_n        (msel_n),
        .cd_out        (cd_out),
        .datadir       (datadir),
        .sd_ctrl       (sd_ctrl)
    );

    tb_checker chk_i (
        .clk108_w   (clk108_w),
        .check      (check_now),
        .name       (cur_name),
        .exp_cd     (exp_cd),
        .exp_dir    (exp_dir),
        .exp_ctrl   (exp_ctrl),
        .cd_out     (cd_out),
        .datadir    (datadir),
        .sd_ctrl    (sd_ctrl),
        .pass_count (pass_count),
        .fail_count (fail_count)
    );

    always #5 clk108_w = ~clk108_w;

    ////////////////////////////////////////
    // external address/control multiplexer
    always_comb begin
        case (msel_n)
            msx_pkg::MSEL_LO:  mp = pins.addr[7:0];
            msx_pkg::MSEL_HI:  mp = pins.addr[15:8];
            msx_pkg::MSEL_CTL: mp = {pins.m1_n, 5'b11111, pins.iorq_n, pins.merq_n};
            default:           mp = 8'hFF;   // nothing selected
        endcase
    end

    assign cd_in   = pins.data;
    assign rd_n    = pins.rd_n;
    assign wr_n    = pins.wr_n;
    assign sltsl_n = pins.sltsl_n;

    always @(posedge clk108_w) begin
        cycles <= cycles + 1;
        if (cycles >= ROW_CYCLES * n_rows + 100) begin
            $display("timeout after %0d cycles, the table did not finish", cycles);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32 22 2 1
    endfunction

    task automatic new_status();
        logic [11:0] bits;
        for (int i = 0; i < 12; i++) begin
            lfsr_q  = lfsr_next(lfsr_q);
            bits[i] = lfsr_q[0];
        end
        sd_status = bits;
    endtask

    function automatic msx_pkg::bus_cycle_t pins_for(input kind_e kind, input msx_pkg::addr_t addr,
                                                     input msx_pkg::byte_t data);
        msx_pkg::bus_cycle_t p;
        p      = '1;   // all strobes inactive
        p.addr = addr;
        p.data = data;
        case (kind)
            K_WR:    {p.sltsl_n, p.merq_n, p.wr_n} = 3'b000;
            K_RD:    {p.sltsl_n, p.merq_n, p.rd_n} = 3'b000;
            K_IO:    {p.iorq_n, p.wr_n} = 2'b00;
            default: p.addr = 16'h0000;
        endcase
        pins_for = p;
    endfunction

    task automatic add_row(input logic [127:0] name, input kind_e kind, input msx_pkg::addr_t addr,
                           input msx_pkg::byte_t data, input cd_src_e src,
                           input msx_pkg::byte_t val, input logic dir, input logic en,
                           input logic [2:0] rwi, input msx_pkg::sector_t sector,
                           input msx_pkg::mapper_type_t mt, input logic scc);
        row_t r;
        r.name   = name;
        r.kind   = kind;
        r.addr   = addr;
        r.data   = data;
        r.cd_src = src;
        r.cd_val = val;
        r.dir    = dir;
        r.ctrl.sd_en = en;
        {r.ctrl.rstart, r.ctrl.wstart, r.ctrl.init} = rwi;
        r.ctrl.sector      = sector;
        r.ctrl.mapper_type = mt;
        r.ctrl.scc_enable  = scc;
        rows[n_rows] = r;
        n_rows = n_rows + 1;
    endtask

    // called right after a falling edge and takes ROW_CYCLES clocks
    task automatic run_row(input int idx);
        row_t r;
        int   hold;
        r    = rows[idx];
        hold = HOLD_CYCLES;
        new_status();
        pins     = pins_for(r.kind, r.addr, r.data);
        cur_name = r.name;
        if (r.kind == K_DONE) begin
            sd_done = 1'b1;
            @(negedge clk108_w);
            sd_done = 1'b0;
            hold = hold - 1;
        end
        repeat (hold - 1) @(negedge clk108_w);
        case (r.cd_src)
            CD_VAL:   last_cd = r.cd_val;
            CD_STAT:  last_cd = {sd_status.busy, 5'b00000, sd_status.timeout_error,
                                 sd_status.crc_error};
            CD_CTYPE: last_cd = {6'b000000, sd_status.card_type};
            CD_MID:   last_cd = sd_status.mid;
            default: begin
            end
        endcase
        exp_cd    = last_cd;
        exp_dir   = r.dir;
        exp_ctrl  = r.ctrl;
        check_now = 1'b1;
        @(negedge clk108_w);
        check_now = 1'b0;
        pins = pins_for(K_IDLE, 16'h0000, 8'h00);   // release the bus between rows
        repeat (IDLE_CYCLES) @(negedge clk108_w);
    endtask

    ////////////////////////////////////////
    initial begin
        clk108_w      = 1'b0;
        ram_enabled_w = 1'b0;
        sd_done       = 1'b0;
        sd_status     = '0;
        check_now     = 1'b0;
        cur_name      = '0;
        exp_cd        = '0;
        exp_dir       = 1'b1;
        exp_ctrl      = '0;
        lfsr_q        = 32'hcfbf_ab10;
        last_cd       = 8'hFF;   // cd_out out of reset
        pins          = pins_for(K_IDLE, 16'h0000, 8'h00);

        // name, kind, addr, data, cd source, cd value, datadir, sd_en, rwi, sector, map, scc
        add_row("reset_idle", K_IDLE, 16'h0000, 8'h00, CD_KEEP, 8'h00, 1, 0, 3'b000, 32'h0, 1, 1);
        add_row("en_write", K_WR, 16'h7E00, 8'h01, CD_KEEP, 8'h00, 1, 1, 3'b000, 32'h0, 1, 1);
        add_row("en_read", K_RD, 16'h7E00, 8'h00, CD_VAL, 8'h01, 0, 1, 3'b000, 32'h0, 1, 1);
        add_row("unmapped", K_RD, 16'h7E20, 8'h00, CD_VAL, 8'hFF, 0, 1, 3'b000, 32'h0, 1, 1);
        add_row("saddr_0", K_WR, 16'h7E03, 8'h11, CD_KEEP, 8'h00, 1, 1, 3'b000, 32'h11, 1, 1);
        add_row("saddr_1", K_WR, 16'h7E04, 8'h22, CD_KEEP, 8'h00, 1, 1, 3'b000, 32'h2211, 1, 1);
        add_row("saddr_2", K_WR, 16'h7E05, 8'h33, CD_KEEP, 8'h00, 1, 1, 3'b000, 32'h332211, 1, 1);
        add_row("saddr_3", K_WR, 16'h7E06, 8'h44, CD_KEEP, 8'h00, 1, 1, 3'b000, 32'h44332211, 1, 1);
        add_row("cmd_83", K_WR, 16'h7E01, 8'h83, CD_KEEP, 8'h00, 1, 1, 3'b111, 32'h44332211, 1, 1);
        add_row("sd_done", K_DONE, 16'h0000, 8'h00, CD_KEEP, 8'h00, 1, 1, 3'b001, 32'h44332211, 1, 1);
        add_row("status", K_RD, 16'h7E02, 8'h00, CD_STAT, 8'h00, 0, 1, 3'b001, 32'h44332211, 1, 1);
        add_row("ctype", K_RD, 16'h7E0E, 8'h00, CD_CTYPE, 8'h00, 0, 1, 3'b001, 32'h44332211, 1, 1);
        add_row("mid", K_RD, 16'h7E0F, 8'h00, CD_MID, 8'h00, 0, 1, 3'b001, 32'h44332211, 1, 1);
        add_row("cfg_16", K_IO, 16'h008F, 8'h16, CD_KEEP, 8'h00, 1, 1, 3'b001, 32'h44332211, 2, 0);
        add_row("cfg_08", K_IO, 16'h008F, 8'h08, CD_KEEP, 8'h00, 1, 1, 3'b001, 32'h44332211, 3, 0);
        add_row("cfg_04", K_IO, 16'h008F, 8'h04, CD_KEEP, 8'h00, 1, 1, 3'b001, 32'h44332211, 0, 0);
        add_row("cfg_05", K_IO, 16'h008F, 8'h05, CD_KEEP, 8'h00, 1, 1, 3'b001, 32'h44332211, 1, 1);
        add_row("cfg_42", K_IO, 16'h008F, 8'h42, CD_KEEP, 8'h00, 1, 1, 3'b001, 32'h44332211, 1, 1);
        add_row("en_clear", K_WR, 16'h7E00, 8'h00, CD_KEEP, 8'h00, 1, 0, 3'b001, 32'h44332211, 1, 1);
        add_row("cmd_off", K_WR, 16'h7E01, 8'h03, CD_KEEP, 8'h00, 1, 0, 3'b001, 32'h44332211, 1, 1);
        add_row("status_off", K_RD, 16'h7E02, 8'h00, CD_KEEP, 8'h00, 0, 0, 3'b001, 32'h44332211, 1, 1);

        repeat (16) @(posedge clk108_w);
        @(negedge clk108_w);
        ram_enabled_w = 1'b1;

        for (int i = 0; i < n_rows; i++) begin
            run_row(i);
        end

        $display("rows %0d, ok %0d, errors %0d", n_rows, pass_count, fail_count);
        if (fail_count == 0 && pass_count == n_rows) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
msx_pkg.sv
bus_mux_scan.sv
sdc_decode.sv
sdc_regs.sv
sdc_readback.sv
msx_cart_top.sv
tb_checker.sv
tb_cart.sv

//--- Bender.yml
package:
  name: msx_cart

sources:
  - msx_pkg.sv
  - bus_mux_scan.sv
  - sdc_decode.sv
  - sdc_regs.sv
  - sdc_readback.sv
  - msx_cart_top.sv
  - target: simulation
    files:
      - tb_checker.sv
      - tb_cart.sv
